//--- all.f
+incdir+verilog
verilog/cu_pkg.sv
verilog/cu_ifs.sv
verilog/instr_decoder.sv
verilog/cu_sequencer.sv
verilog/mem_port_ctrl.sv
verilog/alu_pc_ctrl.sv
verilog/cu_top.sv
tb/tb_cu.sv

//--- tb/tb_cu.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module tb_cu;

	localparam int N_TESTS = 200;
	localparam int CLK_NS = 100;
	// longest sequence is 5 cycles plus slack for reset
	localparam int TIMEOUT_NS = N_TESTS * 5 * CLK_NS + 20 * CLK_NS;

	logic                   clk;
	logic                   rst;
	logic [`CU_XLEN-1:0]    i_instr;
	logic                   i_branch;
	logic [`CU_WADDR_W-1:0] o_mem_a1;
	logic [`CU_WADDR_W-1:0] o_mem_a2;
	logic [`CU_WE_W-1:0]    o_mem_we1;
	logic [`CU_WE_W-1:0]    o_mem_we2;
	logic [1:0]             o_mem_a1_sel;
	logic                   o_mem_a2_sel;
	logic                   o_mem_w1_sel;
	logic [1:0]             o_alu_src1_sel;
	logic [1:0]             o_alu_src2_sel;
	logic [1:0]             o_imm_sel;
	logic [`CU_ALUOP_W-1:0] o_alu_op;
	logic                   o_instr_we;
	logic                   o_old_pc_we;
	logic                   o_pc_we;

	integer seed = 32'h3b67;
	int errors = 0;
	int checks = 0;

	// model state and decoded fields
	logic [`CU_STATE_W-1:0] mstate;
	logic [2:0]             m_cls;
	logic [4:0]             m_op;
	logic [1:0]             m_imm;
	logic [3:0]             m_mask;
	logic [4:0]             m_rs1;
	logic [4:0]             m_rs2;
	logic [4:0]             m_rd;

	// expected outputs for the current model state
	logic [31:0] e_a1;
	logic [31:0] e_a2;
	logic [31:0] e_we1;
	logic [31:0] e_we2;
	logic [31:0] e_a1_sel;
	logic [31:0] e_a2_sel;
	logic [31:0] e_w1_sel;
	logic [31:0] e_op;
	logic [31:0] e_src1;
	logic [31:0] e_src2;
	logic [31:0] e_imm;
	logic [31:0] e_pc_we;
	logic [31:0] e_old_pc_we;
	logic [31:0] e_instr_we;

	cu_top cu_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// funct3 order of the base arithmetic ops
	function automatic logic [4:0] op_by_f3(input logic [2:0] f3);
		case (f3)
			3'b000:  return `ALU_ADD;
			3'b001:  return `ALU_SLL;
			3'b010:  return `ALU_SLT;
			3'b011:  return `ALU_SLTU;
			3'b100:  return `ALU_XOR;
			3'b101:  return `ALU_SRL;
			3'b110:  return `ALU_OR;
			default: return `ALU_AND;
		endcase
	endfunction

	function automatic string class_name(input logic [2:0] cls);
		case (cls)
			`CLS_ARITH:  return "arith";
			`CLS_IMM:    return "imm";
			`CLS_LOAD:   return "load";
			`CLS_STORE:  return "store";
			`CLS_BRANCH: return "branch";
			default:     return "unknown";
		endcase
	endfunction

	// fetch to fetch cycle counts per class
	function automatic int cycles_for(input logic [2:0] cls, input logic br);
		case (cls)
			`CLS_LOAD:   return 5;
			`CLS_BRANCH: return br ? 5 : 4;
			`CLS_BAD:    return 2;
			default:     return 4;
		endcase
	endfunction

	// random word with one of five opcodes or jal as the invalid one
	task automatic new_instruction();
		logic [31:0] w;
		logic [31:0] rnd;
		logic [2:0]  f3;
		int          pick;
		w = $random(seed);
		pick = $unsigned($random(seed)) % 6;
		case (pick)
			0:       w[6:0] = `OPC_ARITH;
			1:       w[6:0] = `OPC_IMM;
			2:       w[6:0] = `OPC_LOAD;
			3:       w[6:0] = `OPC_STORE;
			4:       w[6:0] = `OPC_BRANCH;
			default: w[6:0] = 7'b1101111;
		endcase
		i_instr = w;
		rnd = $random(seed);
		i_branch = rnd[0];
		f3 = w[14:12];
		m_rs1 = w[19:15];
		m_rs2 = w[24:20];
		m_rd = w[11:7];
		m_cls = `CLS_BAD;
		m_op = `ALU_ADD;
		m_imm = `IMM_I;
		m_mask = `WE_NONE;
		if (w[6:0] == `OPC_ARITH || w[6:0] == `OPC_IMM) begin
			m_cls = (w[6:0] == `OPC_ARITH) ? `CLS_ARITH : `CLS_IMM;
			m_op = op_by_f3(f3);
			// bit 30 is funct7[5] or imm[10]
			if (w[30] && f3 == 3'b101)
				m_op = `ALU_SRA;
			if (w[30] && f3 == 3'b000 && m_cls == `CLS_ARITH)
				m_op = `ALU_SUB;
		end else if (w[6:0] == `OPC_LOAD) begin
			m_cls = `CLS_LOAD;
			m_op = (f3 == 3'b000) ? `ALU_LB : (f3 == 3'b001) ? `ALU_LH :
				(f3 == 3'b100) ? `ALU_LBU : (f3 == 3'b101) ? `ALU_LHU : `ALU_LW;
		end else if (w[6:0] == `OPC_STORE) begin
			m_cls = `CLS_STORE;
			m_imm = `IMM_S;
			m_mask = (f3 == 3'b000) ? `WE_B : (f3 == 3'b001) ? `WE_H :
				(f3 == 3'b010) ? `WE_W : `WE_NONE;
		end else if (w[6:0] == `OPC_BRANCH) begin
			m_cls = `CLS_BRANCH;
			m_imm = `IMM_B;
			// 010 and 011 are reserved and act as beq
			m_op = (f3 == 3'b001) ? `ALU_BNE : (f3 == 3'b100) ? `ALU_BLT :
				(f3 == 3'b101) ? `ALU_BGE : (f3 == 3'b110) ? `ALU_BLTU :
				(f3 == 3'b111) ? `ALU_BGEU : `ALU_BEQ;
		end
	endtask

	task automatic set_expected();
		e_a1 = 0;
		e_a2 = 0;
		e_we1 = `WE_NONE;
		e_we2 = `WE_NONE;
		e_a1_sel = `A1_REG;
		e_a2_sel = `A2_REG;
		e_w1_sel = `W1_ALU;
		e_op = `ALU_ADD;
		e_src1 = `SRC1_PC;
		e_src2 = `SRC2_ADD4;
		e_imm = `IMM_I;
		e_pc_we = 0;
		e_old_pc_we = 0;
		e_instr_we = 0;
		case (mstate)
			`ST_FETCH: begin
				e_a1_sel = `A1_PC;
				e_pc_we = 1;
				e_old_pc_we = 1;
			end
			`ST_DECODE: e_instr_we = 1;
			`ST_ARITH, `ST_BRANCH_1, `ST_STORE_1: begin
				e_a1 = m_rs1;
				e_a2 = m_rs2;
			end
			`ST_IMM, `ST_LOAD_1: e_a1 = m_rs1;
			`ST_LOAD_2, `ST_STORE_2: begin
				e_src1 = `SRC1_MEM_R1;
				e_src2 = `SRC2_IMM;
				e_imm = m_imm;
			end
			`ST_LOAD_3: begin
				e_a1 = m_rd;
				e_we1 = `WE_W;
				e_src2 = `SRC2_MEM_R2;
				e_op = m_op;
			end
			`ST_BRANCH_EXEC: begin
				e_src1 = `SRC1_OLD_PC;
				e_src2 = `SRC2_IMM;
				e_imm = `IMM_B;
				e_pc_we = 1;
			end
			default: ;
		endcase
		// reg-reg ops and branch compares read both ports
		if (mstate == `ST_ARITH || mstate == `ST_ARITH_WB || mstate == `ST_BRANCH_2) begin
			e_src1 = `SRC1_MEM_R1;
			e_src2 = `SRC2_MEM_R2;
			e_op = m_op;
		end
		if (mstate == `ST_IMM || mstate == `ST_IMM_WB) begin
			e_src1 = `SRC1_MEM_R1;
			e_src2 = `SRC2_IMM;
			e_imm = m_imm;
			e_op = m_op;
		end
		// write-back of rd through port 2
		if (mstate == `ST_ARITH_WB || mstate == `ST_IMM_WB) begin
			e_a2 = m_rd;
			e_we2 = `WE_W;
		end
		if (mstate == `ST_LOAD_2)
			e_a2_sel = `A2_ALU;
		if (mstate == `ST_STORE_2) begin
			e_a1_sel = `A1_ALU;
			e_w1_sel = `W1_MEM_R2;
			e_we1 = m_mask;
		end
	endtask

	task automatic check_sig(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h (state %0d instr %h)",
				name, got, exp, mstate, i_instr);
			errors++;
		end
	endtask

	task automatic compare_outputs();
		set_expected();
		check_sig("o_mem_a1", o_mem_a1, e_a1);
		check_sig("o_mem_a2", o_mem_a2, e_a2);
		check_sig("o_mem_we1", o_mem_we1, e_we1);
		check_sig("o_mem_we2", o_mem_we2, e_we2);
		check_sig("o_mem_a1_sel", o_mem_a1_sel, e_a1_sel);
		check_sig("o_mem_a2_sel", o_mem_a2_sel, e_a2_sel);
		check_sig("o_mem_w1_sel", o_mem_w1_sel, e_w1_sel);
		check_sig("o_alu_op", o_alu_op, e_op);
		check_sig("o_alu_src1_sel", o_alu_src1_sel, e_src1);
		check_sig("o_alu_src2_sel", o_alu_src2_sel, e_src2);
		check_sig("o_imm_sel", o_imm_sel, e_imm);
		check_sig("o_pc_we", o_pc_we, e_pc_we);
		check_sig("o_old_pc_we", o_old_pc_we, e_old_pc_we);
		check_sig("o_instr_we", o_instr_we, e_instr_we);
	endtask

	// one state per clock as the sequencer steps
	task automatic step_model();
		case (mstate)
			`ST_FETCH: mstate = `ST_DECODE;
			`ST_DECODE: begin
				case (m_cls)
					`CLS_ARITH:  mstate = `ST_ARITH;
					`CLS_IMM:    mstate = `ST_IMM;
					`CLS_LOAD:   mstate = `ST_LOAD_1;
					`CLS_STORE:  mstate = `ST_STORE_1;
					`CLS_BRANCH: mstate = `ST_BRANCH_1;
					default:     mstate = `ST_FETCH;
				endcase
			end
			`ST_ARITH:    mstate = `ST_ARITH_WB;
			`ST_IMM:      mstate = `ST_IMM_WB;
			`ST_LOAD_1:   mstate = `ST_LOAD_2;
			`ST_LOAD_2:   mstate = `ST_LOAD_3;
			`ST_STORE_1:  mstate = `ST_STORE_2;
			`ST_BRANCH_1: mstate = `ST_BRANCH_2;
			`ST_BRANCH_2: mstate = i_branch ? `ST_BRANCH_EXEC : `ST_FETCH;
			default:      mstate = `ST_FETCH;
		endcase
	endtask

	initial begin
		int cyc;
		int errs_before;
		logic busy;
		rst = 1'b1;
		i_instr = '0;
		i_branch = 1'b0;
		mstate = `ST_FETCH;
		m_cls = `CLS_BAD;
		repeat (5) @(negedge clk);
		// first cycle after reset shows the fetch pattern
		errs_before = errors;
		check_sig("o_mem_a1_sel", o_mem_a1_sel, `A1_PC);
		check_sig("o_pc_we", o_pc_we, 1);
		check_sig("o_old_pc_we", o_old_pc_we, 1);
		check_sig("o_mem_we1", o_mem_we1, `WE_NONE);
		check_sig("o_mem_we2", o_mem_we2, `WE_NONE);
		check_sig("o_instr_we", o_instr_we, 0);
		$display("test 0 reset: %s", (errors == errs_before) ? "passed" : "failed");
		rst = 1'b0;
		for (int t = 1; t <= N_TESTS; t++) begin
			errs_before = errors;
			new_instruction();
			cyc = 0;
			busy = 1'b1;
			while (busy) begin
				compare_outputs();
				step_model();
				cyc++;
				@(negedge clk);
				// old pc is written only in fetch
				busy = !o_old_pc_we && cyc < 8;
			end
			if (!o_old_pc_we) begin
				$display("no return to fetch within 8 cycles on test %0d", t);
				errors++;
			end else if (cyc != cycles_for(m_cls, i_branch)) begin
				$display("FAILED sequence length: got %h expected %h", cyc,
					cycles_for(m_cls, i_branch));
				errors++;
			end
			$display("test %0d %s instr=%h branch=%0b cycles=%0d: %s", t, class_name(m_cls),
				i_instr, i_branch, cyc, (errors == errs_before) ? "passed" : "failed");
		end
		$display("tests %0d, checks %0d, errors %0d", N_TESTS + 1, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the run did not complete %0d instructions in time", N_TESTS);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- verilog/cu_top.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module cu_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`CU_XLEN-1:0]    i_instr,
	input  logic                   i_branch,
	output logic [`CU_WADDR_W-1:0] o_mem_a1,
	output logic [`CU_WADDR_W-1:0] o_mem_a2,
	output logic [`CU_WE_W-1:0]    o_mem_we1,
	output logic [`CU_WE_W-1:0]    o_mem_we2,
	output logic [1:0]             o_mem_a1_sel,
	output logic                   o_mem_a2_sel,
	output logic                   o_mem_w1_sel,
	output logic [1:0]             o_alu_src1_sel,
	output logic [1:0]             o_alu_src2_sel,
	output logic [1:0]             o_imm_sel,
	output logic [`CU_ALUOP_W-1:0] o_alu_op,
	output logic                   o_instr_we,
	output logic                   o_old_pc_we,
	output logic                   o_pc_we
);

	logic [`CU_STATE_W-1:0] state;

	dec_if      dec_bus ();
	mem_ctrl_if mem_bus ();
	dp_ctrl_if  dp_bus ();

	instr_decoder u_dec (.i_instr(i_instr), .o_dec(dec_bus.dec));

	cu_sequencer u_seq (
		.clk      (clk),
		.rst      (rst),
		.i_branch (i_branch),
		.i_dec    (dec_bus.seq),
		.o_state  (state)
	);

	mem_port_ctrl u_mem (.i_state(state), .i_dec(dec_bus.ctrl), .o_mem(mem_bus.drv));

	alu_pc_ctrl u_alu (.i_state(state), .i_dec(dec_bus.ctrl), .o_dp(dp_bus.drv));

	// memory side
	assign o_mem_a1     = mem_bus.a1;
	assign o_mem_a2     = mem_bus.a2;
	assign o_mem_we1    = mem_bus.we1;
	assign o_mem_we2    = mem_bus.we2;
	assign o_mem_a1_sel = mem_bus.a1_sel;
	assign o_mem_a2_sel = mem_bus.a2_sel;
	assign o_mem_w1_sel = mem_bus.w1_sel;

	// datapath side
	assign o_alu_op       = dp_bus.alu_op;
	assign o_alu_src1_sel = dp_bus.src1_sel;
	assign o_alu_src2_sel = dp_bus.src2_sel;
	assign o_imm_sel      = dp_bus.imm_sel;
	assign o_pc_we        = dp_bus.pc_we;
	assign o_old_pc_we    = dp_bus.old_pc_we;
	assign o_instr_we     = dp_bus.instr_we;

endmodule

//--- verilog/alu_pc_ctrl.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module alu_pc_ctrl (
	input  logic [`CU_STATE_W-1:0] i_state,
	dec_if.ctrl                    i_dec,
	dp_ctrl_if.drv                 o_dp
);

	always_comb begin
		// idle pattern is pc + 4
		o_dp.alu_op    = `ALU_ADD;
		o_dp.src1_sel  = `SRC1_PC;
		o_dp.src2_sel  = `SRC2_ADD4;
		o_dp.imm_sel   = `IMM_I;
		o_dp.pc_we     = 1'b0;
		o_dp.old_pc_we = 1'b0;
		o_dp.instr_we  = 1'b0;
		case (i_state)
			// advance pc, keep the old one for branch targets
			`ST_FETCH: begin
				o_dp.pc_we     = 1'b1;
				o_dp.old_pc_we = 1'b1;
			end
			`ST_DECODE: o_dp.instr_we = 1'b1;
			// reg-reg op or branch compare
			`ST_ARITH, `ST_ARITH_WB, `ST_BRANCH_2: begin
				o_dp.src1_sel = `SRC1_MEM_R1;
				o_dp.src2_sel = `SRC2_MEM_R2;
				o_dp.alu_op   = i_dec.alu_op;
			end
			`ST_IMM, `ST_IMM_WB: begin
				o_dp.src1_sel = `SRC1_MEM_R1;
				o_dp.src2_sel = `SRC2_IMM;
				o_dp.imm_sel  = i_dec.imm_sel;
				o_dp.alu_op   = i_dec.alu_op;
			end
			// effective address rs1 + imm
			`ST_LOAD_2, `ST_STORE_2: begin
				o_dp.src1_sel = `SRC1_MEM_R1;
				o_dp.src2_sel = `SRC2_IMM;
				o_dp.imm_sel  = i_dec.imm_sel;
			end
			// sign or zero extend the loaded word
			`ST_LOAD_3: begin
				o_dp.src2_sel = `SRC2_MEM_R2;
				o_dp.alu_op   = i_dec.alu_op;
			end
			// branch target old pc + imm
			`ST_BRANCH_EXEC: begin
				o_dp.src1_sel = `SRC1_OLD_PC;
				o_dp.src2_sel = `SRC2_IMM;
				o_dp.imm_sel  = i_dec.imm_sel;
				o_dp.pc_we    = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

//--- verilog/mem_port_ctrl.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module mem_port_ctrl (
	input  logic [`CU_STATE_W-1:0] i_state,
	dec_if.ctrl                    i_dec,
	mem_ctrl_if.drv                o_mem
);

	localparam int PAD_W = `CU_WADDR_W - `CU_REG_W;

	// register file occupies the low words of memory
	logic [`CU_WADDR_W-1:0] rs1_addr;
	logic [`CU_WADDR_W-1:0] rs2_addr;
	logic [`CU_WADDR_W-1:0] rd_addr;

	assign rs1_addr = {{PAD_W{1'b0}}, i_dec.rs1};
	assign rs2_addr = {{PAD_W{1'b0}}, i_dec.rs2};
	assign rd_addr  = {{PAD_W{1'b0}}, i_dec.rd};

	always_comb begin
		o_mem.a1     = '0;
		o_mem.a2     = '0;
		o_mem.we1    = `WE_NONE;
		o_mem.we2    = `WE_NONE;
		o_mem.a1_sel = `A1_REG;
		o_mem.a2_sel = `A2_REG;
		o_mem.w1_sel = `W1_ALU;
		case (i_state)
			// instruction read through port 1
			`ST_FETCH: o_mem.a1_sel = `A1_PC;
			// read both source registers
			`ST_ARITH, `ST_STORE_1, `ST_BRANCH_1: begin
				o_mem.a1 = rs1_addr;
				o_mem.a2 = rs2_addr;
			end
			`ST_IMM, `ST_LOAD_1: o_mem.a1 = rs1_addr;
			// alu result back into rd via port 2
			`ST_ARITH_WB, `ST_IMM_WB: begin
				o_mem.a2  = rd_addr;
				o_mem.we2 = `WE_W;
			end
			// data word at rs1 + imm
			`ST_LOAD_2: o_mem.a2_sel = `A2_ALU;
			// extended load data into rd via port 1
			`ST_LOAD_3: begin
				o_mem.a1  = rd_addr;
				o_mem.we1 = `WE_W;
			end
			`ST_STORE_2: begin
				o_mem.a1_sel = `A1_ALU;
				// rs2 value still on read port 2
				o_mem.w1_sel = `W1_MEM_R2;
				o_mem.we1    = i_dec.st_mask;
			end
			default: ;
		endcase
	end

endmodule

//--- verilog/cu_sequencer.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module cu_sequencer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   i_branch,
	dec_if.seq                     i_dec,
	output logic [`CU_STATE_W-1:0] o_state
);

	logic [`CU_STATE_W-1:0] state;
	logic [`CU_STATE_W-1:0] next_state;

	always_ff @(posedge clk) begin
		if (rst)
			state <= `ST_FETCH;
		else
			state <= next_state;
	end

	always_comb begin
		case (state)
			`ST_FETCH: next_state = `ST_DECODE;
			// dispatch on the class decoded from the word on the memory bus
			`ST_DECODE: begin
				case (i_dec.op_class)
					`CLS_ARITH:  next_state = `ST_ARITH;
					`CLS_IMM:    next_state = `ST_IMM;
					`CLS_LOAD:   next_state = `ST_LOAD_1;
					`CLS_STORE:  next_state = `ST_STORE_1;
					`CLS_BRANCH: next_state = `ST_BRANCH_1;
					default:     next_state = `ST_FETCH;
				endcase
			end
			`ST_ARITH:    next_state = `ST_ARITH_WB;
			`ST_IMM:      next_state = `ST_IMM_WB;
			`ST_LOAD_1:   next_state = `ST_LOAD_2;
			`ST_LOAD_2:   next_state = `ST_LOAD_3;
			`ST_STORE_1:  next_state = `ST_STORE_2;
			`ST_BRANCH_1: next_state = `ST_BRANCH_2;
			// taken branch needs one more cycle to load pc
			`ST_BRANCH_2: next_state = i_branch ? `ST_BRANCH_EXEC : `ST_FETCH;
			// write-back and exec states, plus any stray code
			default:      next_state = `ST_FETCH;
		endcase
	end

	assign o_state = state;

endmodule

//--- verilog/instr_decoder.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module instr_decoder import cu_pkg::*; (
	input  instr_u i_instr,
	dec_if.dec     o_dec
);

	logic [6:0] opc;
	logic [2:0] f3;

	assign opc = i_instr.r.opcode;
	assign f3  = i_instr.r.funct3;

	// register indices sit at the same bits in every format
	assign o_dec.rs1 = i_instr.r.rs1;
	assign o_dec.rs2 = i_instr.r.rs2;
	assign o_dec.rd  = i_instr.r.rd;

	// funct3 table shared by reg-reg and reg-imm arithmetic
	function automatic logic [`CU_ALUOP_W-1:0] arith_op(
		input logic [2:0] fn,
		input logic       alt_sub,
		input logic       alt_sra
	);
		case (fn)
			3'b000:  arith_op = alt_sub ? `ALU_SUB : `ALU_ADD;
			3'b001:  arith_op = `ALU_SLL;
			3'b010:  arith_op = `ALU_SLT;
			3'b011:  arith_op = `ALU_SLTU;
			3'b100:  arith_op = `ALU_XOR;
			3'b101:  arith_op = alt_sra ? `ALU_SRA : `ALU_SRL;
			3'b110:  arith_op = `ALU_OR;
			default: arith_op = `ALU_AND;
		endcase
	endfunction

	always_comb begin
		o_dec.op_class = `CLS_BAD;
		o_dec.alu_op   = `ALU_ADD;
		o_dec.imm_sel  = `IMM_I;
		o_dec.st_mask  = `WE_NONE;
		case (opc)
			`OPC_ARITH: begin
				o_dec.op_class = `CLS_ARITH;
				// funct7 bit 5 selects sub and sra
				o_dec.alu_op = arith_op(f3, i_instr.r.funct7[5], i_instr.r.funct7[5]);
			end
			`OPC_IMM: begin
				o_dec.op_class = `CLS_IMM;
				// no subi; srai flagged by imm bit 10
				o_dec.alu_op = arith_op(f3, 1'b0, i_instr.i.imm12[10]);
			end
			`OPC_LOAD: begin
				o_dec.op_class = `CLS_LOAD;
				case (f3)
					3'b000:  o_dec.alu_op = `ALU_LB;
					3'b001:  o_dec.alu_op = `ALU_LH;
					3'b100:  o_dec.alu_op = `ALU_LBU;
					3'b101:  o_dec.alu_op = `ALU_LHU;
					default: o_dec.alu_op = `ALU_LW;
				endcase
			end
			`OPC_STORE: begin
				o_dec.op_class = `CLS_STORE;
				o_dec.imm_sel  = `IMM_S;
				case (f3)
					3'b000:  o_dec.st_mask = `WE_B;
					3'b001:  o_dec.st_mask = `WE_H;
					3'b010:  o_dec.st_mask = `WE_W;
					default: o_dec.st_mask = `WE_NONE;
				endcase
			end
			`OPC_BRANCH: begin
				o_dec.op_class = `CLS_BRANCH;
				o_dec.imm_sel  = `IMM_B;
				// reserved funct3 falls back to beq
				case (f3)
					3'b001:  o_dec.alu_op = `ALU_BNE;
					3'b100:  o_dec.alu_op = `ALU_BLT;
					3'b101:  o_dec.alu_op = `ALU_BGE;
					3'b110:  o_dec.alu_op = `ALU_BLTU;
					3'b111:  o_dec.alu_op = `ALU_BGEU;
					default: o_dec.alu_op = `ALU_BEQ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

//--- verilog/cu_ifs.sv
`timescale 1ns/1ps
`include "cu_params.svh"

// decoded instruction fields
interface dec_if;
	logic [`CU_CLASS_W-1:0] op_class;
	logic [`CU_REG_W-1:0]   rs1;
	logic [`CU_REG_W-1:0]   rs2;
	logic [`CU_REG_W-1:0]   rd;
	logic [`CU_ALUOP_W-1:0] alu_op;
	logic [1:0]             imm_sel;
	logic [`CU_WE_W-1:0]    st_mask;

	modport dec (output op_class, rs1, rs2, rd, alu_op, imm_sel, st_mask);
	// sequencer only branches on the class
	modport seq (input op_class);
	modport ctrl (input rs1, rs2, rd, alu_op, imm_sel, st_mask);
endinterface

// dual-port memory controls
interface mem_ctrl_if;
	logic [`CU_WADDR_W-1:0] a1;
	logic [`CU_WADDR_W-1:0] a2;
	logic [`CU_WE_W-1:0]    we1;
	logic [`CU_WE_W-1:0]    we2;
	logic [1:0]             a1_sel;
	logic                   a2_sel;
	logic                   w1_sel;

	modport drv (output a1, a2, we1, we2, a1_sel, a2_sel, w1_sel);
	modport mon (input a1, a2, we1, we2, a1_sel, a2_sel, w1_sel);
endinterface

// alu and pc register controls
interface dp_ctrl_if;
	logic [`CU_ALUOP_W-1:0] alu_op;
	logic [1:0]             src1_sel;
	logic [1:0]             src2_sel;
	logic [1:0]             imm_sel;
	logic                   pc_we;
	logic                   old_pc_we;
	logic                   instr_we;

	modport drv (output alu_op, src1_sel, src2_sel, imm_sel, pc_we, old_pc_we, instr_we);
	modport mon (input alu_op, src1_sel, src2_sel, imm_sel, pc_we, old_pc_we, instr_we);
endinterface

//--- verilog/cu_pkg.sv
`include "cu_params.svh"

package cu_pkg;

	// register-register layout
	typedef struct packed {
		logic [6:0]           funct7;
		logic [`CU_REG_W-1:0] rs2;
		logic [`CU_REG_W-1:0] rs1;
		logic [2:0]           funct3;
		logic [`CU_REG_W-1:0] rd;
		logic [6:0]           opcode;
	} instr_r_t;

	// register-immediate layout, also used for loads
	typedef struct packed {
		logic [11:0]          imm12;
		logic [`CU_REG_W-1:0] rs1;
		logic [2:0]           funct3;
		logic [`CU_REG_W-1:0] rd;
		logic [6:0]           opcode;
	} instr_i_t;

	// same word, two views
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage

//--- verilog/cu_params.svh
`ifndef CU_PARAMS_SVH
`define CU_PARAMS_SVH

// widths
`define CU_XLEN     32
`define CU_REG_W    5
`define CU_WADDR_W  30
`define CU_WE_W     4
`define CU_ALUOP_W  5
`define CU_STATE_W  4
`define CU_CLASS_W  3

// supported rv32i major opcodes
`define OPC_ARITH   7'b0110011
`define OPC_IMM     7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011

// control states
`define ST_FETCH        4'd0
`define ST_DECODE       4'd1
`define ST_ARITH        4'd2
`define ST_ARITH_WB     4'd3
`define ST_IMM          4'd4
`define ST_IMM_WB       4'd5
`define ST_LOAD_1       4'd6
`define ST_LOAD_2       4'd7
`define ST_LOAD_3       4'd8
`define ST_STORE_1      4'd9
`define ST_STORE_2      4'd10
`define ST_BRANCH_1     4'd11
`define ST_BRANCH_2     4'd12
`define ST_BRANCH_EXEC  4'd13

// op classes seen by the sequencer
`define CLS_ARITH   3'd0
`define CLS_IMM     3'd1
`define CLS_LOAD    3'd2
`define CLS_STORE   3'd3
`define CLS_BRANCH  3'd4
`define CLS_BAD     3'd5

// alu operations
`define ALU_ADD   5'd0
`define ALU_SUB   5'd1
`define ALU_SLL   5'd2
`define ALU_SLT   5'd3
`define ALU_SLTU  5'd4
`define ALU_XOR   5'd5
`define ALU_SRL   5'd6
`define ALU_SRA   5'd7
`define ALU_OR    5'd8
`define ALU_AND   5'd9
// branch compares, result goes back as i_branch
`define ALU_BEQ   5'd10
`define ALU_BNE   5'd11
`define ALU_BLT   5'd12
`define ALU_BGE   5'd13
`define ALU_BLTU  5'd14
`define ALU_BGEU  5'd15
// load extends applied to memory read 2
`define ALU_LB    5'd16
`define ALU_LH    5'd17
`define ALU_LW    5'd18
`define ALU_LBU   5'd19
`define ALU_LHU   5'd20

// memory port address and write-data selects
`define A1_PC      2'd0
`define A1_REG     2'd1
`define A1_ALU     2'd2
`define A2_REG     1'b0
`define A2_ALU     1'b1
`define W1_ALU     1'b0
`define W1_MEM_R2  1'b1

// alu source selects
`define SRC1_PC      2'd0
`define SRC1_MEM_R1  2'd1
`define SRC1_OLD_PC  2'd2
`define SRC2_ADD4    2'd0
`define SRC2_MEM_R2  2'd1
`define SRC2_IMM     2'd2

// immediate types
`define IMM_I  2'd0
`define IMM_S  2'd1
`define IMM_B  2'd2

// byte write enables
`define WE_NONE  4'b0000
`define WE_B     4'b0001
`define WE_H     4'b0011
`define WE_W     4'b1111

`endif
